//--- approx_mul16.f
hdl/approx_mul16_pkg.sv
hdl/array_mul8.sv
hdl/cla32.sv
hdl/operand_ingress.sv
hdl/product_pipeline.sv
hdl/result_egress.sv
hdl/approx_mul16_top.sv
verification/result_checker.sv
verification/approx_mul16_properties.sv
verification/approx_mul16_tb.sv

//--- hdl/approx_mul16_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Approximate 16x16 multiplier shared types
// Operand, request, partial product and result words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package approx_mul16_pkg;

  localparam int half_width = 8;
  localparam int op_width = 16;
  localparam int prod_width = 32;

  typedef logic [half_width-1:0] half_t;

  // Operand seen as one word or as a byte pair
  typedef union packed {
    logic [op_width-1:0] word;
    struct packed {
      half_t hi;
      half_t lo;
    } half;
  } operand_u;

  typedef struct packed {
    operand_u a;
    operand_u b;
    logic     approx;
  } mul_req_t;

  // Quadrant products held in the stage one register
  typedef struct packed {
    logic [op_width-1:0] ll;
    logic [op_width-1:0] lh;
    logic [op_width-1:0] hl;
    logic [op_width-1:0] hh;
  } partial_t;

  typedef struct packed {
    logic [prod_width-1:0] product;
    logic                  approx;
  } mul_res_t;

endpackage

//--- hdl/approx_mul16_top.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Approximate 16x16 multiplier top level
// Credit based request ingress, two stage product pipeline
// and credit based result egress
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module approx_mul16_top import approx_mul16_pkg::*; #(
  parameter int INGRESS_DEPTH = 4,
  parameter int EGRESS_DEPTH = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  input  mul_req_t req,
  output logic     req_credit,
  output logic     res_valid,
  output mul_res_t res,
  input  logic     res_credit
);

  logic     issue_valid;
  logic     issue_ready;
  mul_req_t issue_req;
  logic     done_valid;
  mul_res_t done_res;

  operand_ingress #(
    .INGRESS_DEPTH(INGRESS_DEPTH)
  ) u_ingress (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .issue_ready(issue_ready),
    .issue_valid(issue_valid),
    .issue_req  (issue_req)
  );

  product_pipeline u_pipeline (
    .clk        (clk),
    .reset      (reset),
    .issue_valid(issue_valid),
    .issue_req  (issue_req),
    .done_valid (done_valid),
    .done_res   (done_res)
  );

  result_egress #(
    .EGRESS_DEPTH(EGRESS_DEPTH)
  ) u_egress (
    .clk        (clk),
    .reset      (reset),
    .done_valid (done_valid),
    .done_res   (done_res),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res        (res),
    .issue_ready(issue_ready)
  );

endmodule

//--- hdl/array_mul8.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8x8 unsigned array multiplier
// AND matrix reduced by rows of half and full adders,
// then a ripple row for the upper product bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module array_mul8 import approx_mul16_pkg::*; (
  input  half_t               a,
  input  half_t               b,
  output logic [op_width-1:0] p
);

  // Row sums s and row carries c
  wire [half_width-1:0] s [half_width];
  wire [half_width-2:0] c [1:half_width-1];
  wire [half_width-2:0] r_s;
  wire [half_width-2:0] r_c;

  for (genvar j = 0; j < half_width; j++) begin : g_row0
    assign s[0][j] = a[0] & b[j];
  end

  for (genvar i = 1; i < half_width; i++) begin : g_row
    for (genvar j = 0; j < half_width - 1; j++) begin : g_cell
      if (i == 1) begin : g_ha
        assign s[i][j] = s[i-1][j+1] ^ (a[i] & b[j]);
        assign c[i][j] = s[i-1][j+1] & (a[i] & b[j]);
      end else begin : g_fa
        assign s[i][j] = s[i-1][j+1] ^ (a[i] & b[j]) ^ c[i-1][j];
        assign c[i][j] = (s[i-1][j+1] & (a[i] & b[j])) |
                         (c[i-1][j] & (s[i-1][j+1] ^ (a[i] & b[j])));
      end
    end
    assign s[i][half_width-1] = a[i] & b[half_width-1];
  end

  // Final ripple row
  assign r_s[0] = s[half_width-1][1] ^ c[half_width-1][0];
  assign r_c[0] = s[half_width-1][1] & c[half_width-1][0];
  for (genvar j = 1; j < half_width - 1; j++) begin : g_ripple
    assign r_s[j] = s[half_width-1][j+1] ^ c[half_width-1][j] ^ r_c[j-1];
    assign r_c[j] = (s[half_width-1][j+1] & c[half_width-1][j]) |
                    (r_c[j-1] & (s[half_width-1][j+1] ^ c[half_width-1][j]));
  end

  for (genvar i = 0; i < half_width; i++) begin : g_low
    assign p[i] = s[i][0];
  end
  assign p[op_width-1:half_width] = {r_c[half_width-2], r_s};

endmodule

//--- hdl/cla32.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit carry-lookahead adder
// 4-bit groups with a second lookahead level for group carries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cla32 import approx_mul16_pkg::*; (
  input  logic [prod_width-1:0] a,
  input  logic [prod_width-1:0] b,
  output logic [prod_width-1:0] sum
);

  localparam int groups = prod_width / 4;

  logic [prod_width-1:0] p;
  logic [prod_width-1:0] g;
  logic [groups-1:0]     gp;
  logic [groups-1:0]     gg;
  logic [groups-1:0]     gc;

  assign p = a ^ b;
  assign g = a & b;

  // Group carries with the carry-in tied low
  always_comb begin
    logic term;
    gc[0] = 1'b0;
    for (int k = 1; k < groups; k++) begin
      gc[k] = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        gc[k] = gc[k] | term;
      end
    end
  end

  for (genvar k = 0; k < groups; k++) begin : g_grp
    logic [3:0] p4;
    logic [3:0] g4;
    logic [3:0] c4;

    assign p4 = p[4*k +: 4];
    assign g4 = g[4*k +: 4];

    assign gp[k] = &p4;
    assign gg[k] = g4[3] | (p4[3] & g4[2]) | (p4[3] & p4[2] & g4[1]) |
                   (p4[3] & p4[2] & p4[1] & g4[0]);

    assign c4[0] = gc[k];
    assign c4[1] = g4[0] | (p4[0] & c4[0]);
    assign c4[2] = g4[1] | (p4[1] & g4[0]) | (p4[1] & p4[0] & c4[0]);
    assign c4[3] = g4[2] | (p4[2] & g4[1]) | (p4[2] & p4[1] & g4[0]) |
                   (p4[2] & p4[1] & p4[0] & c4[0]);

    assign sum[4*k +: 4] = p4 ^ c4;
  end

endmodule

//--- hdl/operand_ingress.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request ingress FIFO
// Accepts credit limited requests and issues them to the
// pipeline, returning one credit per pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module operand_ingress import approx_mul16_pkg::*; #(
  parameter int INGRESS_DEPTH = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  input  mul_req_t req,
  output logic     req_credit,
  input  logic     issue_ready,
  output logic     issue_valid,
  output mul_req_t issue_req
);

  localparam int ptr_w = $clog2(INGRESS_DEPTH);
  localparam int cnt_w = $clog2(INGRESS_DEPTH + 1);

  mul_req_t         mem [INGRESS_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             pop;

  assign pop = (count != '0) && issue_ready;

  // Head entry goes out in the cycle of the pop
  assign issue_valid = pop;
  assign issue_req = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (req_valid) begin
      mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      req_credit <= 1'b0;
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(req_valid) - cnt_w'(pop);
      req_credit <= pop;
    end
  end

endmodule

//--- hdl/product_pipeline.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two stage 16x16 product pipeline
// Four quadrant products in stage one, low-by-low dropped in
// approximate mode, and two lookahead sums in stage two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module product_pipeline import approx_mul16_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     issue_valid,
  input  mul_req_t issue_req,
  output logic     done_valid,
  output mul_res_t done_res
);

  partial_t              quad;
  partial_t              s1_part;
  logic                  s1_valid;
  logic                  s1_approx;
  logic [prod_width-1:0] sum_lh;
  logic [prod_width-1:0] sum_all;

  array_mul8 u_mul_ll (
    .a(issue_req.a.half.lo),
    .b(issue_req.b.half.lo),
    .p(quad.ll)
  );

  array_mul8 u_mul_lh (
    .a(issue_req.a.half.lo),
    .b(issue_req.b.half.hi),
    .p(quad.lh)
  );

  array_mul8 u_mul_hl (
    .a(issue_req.a.half.hi),
    .b(issue_req.b.half.lo),
    .p(quad.hl)
  );

  array_mul8 u_mul_hh (
    .a(issue_req.a.half.hi),
    .b(issue_req.b.half.hi),
    .p(quad.hh)
  );

  always_ff @(posedge clk) begin
    s1_part.ll <= issue_req.approx ? '0 : quad.ll;
    s1_part.lh <= quad.lh;
    s1_part.hl <= quad.hl;
    s1_part.hh <= quad.hh;
    s1_approx <= issue_req.approx;
  end

  // {hh, ll} + (lh << 8), then + (hl << 8)
  cla32 u_sum_lh (
    .a  ({s1_part.hh, s1_part.ll}),
    .b  ({{half_width{1'b0}}, s1_part.lh, {half_width{1'b0}}}),
    .sum(sum_lh)
  );

  cla32 u_sum_all (
    .a  (sum_lh),
    .b  ({{half_width{1'b0}}, s1_part.hl, {half_width{1'b0}}}),
    .sum(sum_all)
  );

  always_ff @(posedge clk) begin
    done_res.product <= sum_all;
    done_res.approx <= s1_approx;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      done_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
      done_valid <= s1_valid;
    end
  end

endmodule

//--- hdl/result_egress.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result egress buffer
// Sends results against downstream credits and grants issue
// only while a buffer slot is free for every result in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module result_egress import approx_mul16_pkg::*; #(
  parameter int EGRESS_DEPTH = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     done_valid,
  input  mul_res_t done_res,
  input  logic     res_credit,
  output logic     res_valid,
  output mul_res_t res,
  output logic     issue_ready
);

  localparam int ptr_w = $clog2(EGRESS_DEPTH);
  localparam int cnt_w = $clog2(EGRESS_DEPTH + 1);

  mul_res_t         mem [EGRESS_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] credits;
  logic [cnt_w-1:0] reserved;
  logic [cnt_w-1:0] reserved_next;
  logic [1:0]       grant_q;
  logic             send;
  logic             lapse;

  assign send = (count != '0) && (credits != '0);

  // A grant two cycles back with no result behind it
  assign lapse = grant_q[1] && !done_valid;

  // Stored results plus grants still in the pipeline
  assign reserved_next = reserved + cnt_w'(issue_ready) - cnt_w'(lapse) - cnt_w'(send);

  always_ff @(posedge clk) begin
    if (done_valid) begin
      mem[wr_ptr] <= done_res;
    end
    if (send) begin
      res <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= cnt_w'(EGRESS_DEPTH);
      reserved <= '0;
      grant_q <= '0;
      issue_ready <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      if (done_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(done_valid) - cnt_w'(send);
      credits <= credits + cnt_w'(res_credit) - cnt_w'(send);
      reserved <= reserved_next;
      grant_q <= {grant_q[0], issue_ready};
      issue_ready <= reserved_next < EGRESS_DEPTH;
      res_valid <= send;
    end
  end

endmodule

//--- verification/approx_mul16_properties.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit protocol assertions for the multiplier top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module approx_mul16_properties #(
  parameter int EGRESS_DEPTH = 4
) (
  input logic clk,
  input logic reset,
  input logic req_valid,
  input logic req_credit,
  input logic res_valid,
  input logic res_credit
);

  int held_credits;
  int accepted;
  int returned;
  int failures = 0;

  // Downstream credits and upstream request tally
  always_ff @(posedge clk) begin
    if (reset) begin
      held_credits <= EGRESS_DEPTH;
      accepted <= 0;
      returned <= 0;
    end else begin
      held_credits <= held_credits + int'(res_credit) - int'(res_valid);
      accepted <= accepted + int'(req_valid);
      returned <= returned + int'(req_credit);
    end
  end

  a_res_needs_credit: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> held_credits > 0)
    else begin
      $error("res_valid raised with no downstream credit");
      failures++;
    end

  a_credit_after_accept: assert property (@(posedge clk) disable iff (reset)
    req_credit |-> returned < accepted)
    else begin
      $error("req_credit pulse without an accepted request");
      failures++;
    end

  a_quiet_in_reset: assert property (@(posedge clk)
    reset ##1 reset |-> !res_valid && !req_credit)
    else begin
      $error("res_valid or req_credit high during reset");
      failures++;
    end

endmodule

bind approx_mul16_top approx_mul16_properties #(
  .EGRESS_DEPTH(EGRESS_DEPTH)
) u_props (
  .clk       (clk),
  .reset     (reset),
  .req_valid (req_valid),
  .req_credit(req_credit),
  .res_valid (res_valid),
  .res_credit(res_credit)
);

//--- verification/approx_mul16_tb.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the approximate 16x16 multiplier
// File driven requests under credits, random credit return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module approx_mul16_tb import approx_mul16_pkg::*; ();

  localparam int INGRESS_DEPTH = 4;
  localparam int EGRESS_DEPTH = 4;

  logic        clk = 1'b0;
  logic        reset;
  logic        req_valid;
  mul_req_t    req;
  logic        req_credit;
  logic        res_valid;
  mul_res_t    res;
  logic        res_credit;
  logic        exp_push;
  mul_res_t    exp_res;
  int          value_errors;
  int          results_seen;
  logic [15:0] tst_a [$];
  logic [15:0] tst_b [$];
  logic        tst_mode [$];
  logic [31:0] tst_exp [$];
  int          gap_q [$];
  logic [7:0]  lfsr_state = 8'd96;
  int          n_tests = 0;
  int          limit = 0;
  int          cycle = 0;
  int          credit_pulses = 0;
  int          credit_wait = 0;
  logic        credit_busy = 1'b0;
  int          file_errors = 0;
  int          count_errors = 0;

  always #2 clk = ~clk;

  approx_mul16_top #(
    .INGRESS_DEPTH(INGRESS_DEPTH),
    .EGRESS_DEPTH(EGRESS_DEPTH)
  ) uut (.*);

  result_checker u_checker (.*);

  function automatic logic [31:0] model_product(input logic [15:0] a, input logic [15:0] b,
                                                input logic approx);
    logic [31:0] full;
    logic [31:0] low;
    full = a * b;
    low = a[7:0] * b[7:0];
    return approx ? full - low : full;
  endfunction

  // Galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return (s >> 1) ^ (s[0] ? 8'hb8 : 8'h00);
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (2) begin
      gap = (gap << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          code;
    int          ch;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] fm;
    logic [31:0] fe;
    fd = $fopen("verification/approx_mul16_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test file verification/approx_mul16_tests.txt");
      file_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %h %h %h %h", fa, fb, fm, fe);
        if (code == 4) begin
          tst_a.push_back(fa[15:0]);
          tst_b.push_back(fb[15:0]);
          tst_mode.push_back(fm[0]);
          tst_exp.push_back(fe);
          if (fe !== model_product(fa[15:0], fb[15:0], fm[0])) begin
            $display("test %0d in the file expects %h, the product rule gives %h",
                     n_tests, fe, model_product(fa[15:0], fb[15:0], fm[0]));
            file_errors++;
          end
          n_tests++;
        end else begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end
      end
      $fclose(fd);
      if (n_tests == 0) begin
        $display("the test file holds no tests");
        file_errors++;
      end
    end
  endtask

  task automatic drive_requests();
    int credits;
    int idx;
    credits = INGRESS_DEPTH;
    idx = 0;
    while (idx < n_tests) begin
      @(negedge clk);
      if (req_credit) begin
        credits++;
      end
      req_valid = 1'b0;
      exp_push = 1'b0;
      if (credits > 0) begin
        req.a.word = tst_a[idx];
        req.b.word = tst_b[idx];
        req.approx = tst_mode[idx];
        req_valid = 1'b1;
        exp_res.product = tst_exp[idx];
        exp_res.approx = tst_mode[idx];
        exp_push = 1'b1;
        credits--;
        idx++;
      end
    end
    @(negedge clk);
    req_valid = 1'b0;
    exp_push = 1'b0;
  endtask

  always @(posedge clk) begin
    int gap;
    if (!reset) begin
      if (res_valid) begin
        draw_gap(gap);
        gap_q.push_back(gap);
      end
      if (req_credit) begin
        credit_pulses++;
      end
    end
  end

  // One credit back per result once its gap has run out
  always @(negedge clk) begin
    res_credit = 1'b0;
    if (!credit_busy && gap_q.size() != 0) begin
      credit_wait = gap_q.pop_front();
      credit_busy = 1'b1;
    end
    if (credit_busy) begin
      if (credit_wait == 0) begin
        res_credit = 1'b1;
        credit_busy = 1'b0;
      end else begin
        credit_wait--;
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (limit != 0 && cycle >= limit) begin
      $display("timeout after %0d cycles, only %0d of %0d results arrived, the rest went missing",
               cycle, results_seen, n_tests);
      $display("errors: value %0d, count %0d, file %0d, assertion %0d",
               value_errors, count_errors, file_errors, uut.u_props.failures);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    res_credit = 1'b0;
    exp_push = 1'b0;
    exp_res = '0;
    load_tests();
    limit = n_tests * 32 + 100;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    drive_requests();
    wait (results_seen >= n_tests);
    // Room for any stray result or credit
    repeat (10) @(posedge clk);
    if (credit_pulses != n_tests) begin
      $display("saw %0d req_credit pulses for %0d tests", credit_pulses, n_tests);
      count_errors++;
    end
    if (results_seen != n_tests) begin
      $display("saw %0d results for %0d tests", results_seen, n_tests);
      count_errors++;
    end
    $display("errors: value %0d, count %0d, file %0d, assertion %0d",
             value_errors, count_errors, file_errors, uut.u_props.failures);
    if (value_errors + count_errors + file_errors + uut.u_props.failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verification/approx_mul16_tests.txt
// a b mode expected, all hex
// mode 0 is exact, mode 1 drops the low-by-low partial product
0000 0000 0 00000000
ffff ffff 0 fffe0001
0001 0001 0 00000001
8000 8000 0 40000000
0001 8000 0 00008000
ff00 ff00 0 fe010000
1200 3400 0 03a80000
0100 0080 0 00008000
1234 5678 0 06260060
ffff ffff 1 fffd0200
1234 5678 1 0625e800
ff00 ff00 1 fe010000
1200 0034 1 0003a800
00ff 00ff 1 00000000
0001 0001 1 00000000
8080 8080 1 40800000
abcd 1357 0 0cfa99ab
abcd 1357 1 0cfa5400
fedc 0010 0 000fedc0
fedc 0010 1 000fe000
0080 0100 1 00008000
4321 00ff 1 0042bd00
4321 00ff 0 0042dddf
8000 0001 1 00008000

//--- verification/result_checker.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result checker for the multiplier testbench
// Compares every result with the expected queue, in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module result_checker import approx_mul16_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     res_valid,
  input  mul_res_t res,
  input  logic     exp_push,
  input  mul_res_t exp_res,
  output int       value_errors,
  output int       results_seen
);

  mul_res_t expected [$];
  mul_res_t want;

  initial begin
    value_errors = 0;
    results_seen = 0;
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (exp_push) begin
        expected.push_back(exp_res);
      end
      if (res_valid) begin
        results_seen++;
        if (expected.size() == 0) begin
          $display("result %h arrived at %0t with no request waiting for it",
                   res.product, $time);
          value_errors++;
        end else begin
          want = expected.pop_front();
          if (res.product !== want.product) begin
            $display("ERR %0t res.product expected %h got %h",
                     $time, want.product, res.product);
            value_errors++;
          end
          if (res.approx !== want.approx) begin
            $display("ERR %0t res.approx expected %b got %b",
                     $time, want.approx, res.approx);
            value_errors++;
          end
        end
      end
    end
  end

endmodule
